// File: source/armIsaPkg.sv
package armIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regNum_t;

    // Condition field in bits 31:28
    typedef enum logic [3:0] {
        EQ = 4'h0, NE, CS, CC, MI, PL, VS, VC,
        HI, LS, GE, LT, GT, LE, AL,
        NV = 4'hF  // Never executes
    } condCode_t;

    // Data-processing opcode in bits 24:21
    typedef enum logic [3:0] {
        AND = 4'h0, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
        TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
    } dpOpcode_t;

    typedef enum logic [1:0] {
        LSL = 2'b00,
        LSR = 2'b01,
        ASR = 2'b10,
        ROR = 2'b11
    } shiftType_t;

    // Bits 27:25
    typedef enum logic [2:0] {
        DP_REG_SHIFT = 3'b000,
        DP_IMM       = 3'b001
    } instrClass_t;

    localparam int CondMsb       = 31;
    localparam int CondLsb       = 28;
    localparam int ClassMsb      = 27;
    localparam int OpMsb         = 24;
    localparam int OpLsb         = 21;
    localparam int SBitPos       = 20;
    localparam int RnMsb         = 19;
    localparam int RdMsb         = 15;
    localparam int RmMsb         = 3;

    // Register form
    localparam int ShiftAmtMsb   = 11;
    localparam int ShiftTypeMsb  = 6;
    localparam int ShiftByRegPos = 4;   // Shift by register when set and not handled

    // Immediate form
    localparam int RotMsb        = 11;
    localparam int Imm8Msb       = 7;

endpackage

// File: source/dpPipePkg.sv
package dpPipePkg;

    // ALU function select
    typedef enum logic [3:0] {
        AluAdd     = 4'b0000,
        AluAddC    = 4'b0001,
        AluSub     = 4'b0010,
        AluSubC    = 4'b0011,
        AluRsb     = 4'b0100,
        AluRsbC    = 4'b0101,
        AluAnd     = 4'b0110,
        AluOr      = 4'b0111,
        AluXor     = 4'b1000,
        AluPassA   = 4'b1001,
        AluPassB   = 4'b1010,
        AluNotB    = 4'b1011,
        AluAndNotB = 4'b1100
    } aluOp_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic                  valid;
        armIsaPkg::condCode_t  cond;
        aluOp_t                aluOp;
        logic                  setFlags;
        logic                  writesReg;
        logic                  isImm;
        armIsaPkg::shiftType_t shiftType;
        logic [4:0]            shiftAmt;
        logic [3:0]            rot;
        logic [7:0]            imm8;
        armIsaPkg::regNum_t    dest;
        armIsaPkg::word_t      operandA;  // Rn value
        armIsaPkg::word_t      operandM;  // Rm value that the immediate form ignores
    } decodedOp_t;

    typedef struct packed {
        logic               valid;
        logic               executed;  // Condition passed
        logic               writeEnable;
        armIsaPkg::regNum_t dest;
        armIsaPkg::word_t   value;
        logic               setFlags;
        logic               arithmetic;  // C and V are meaningful
        flags_t             newFlags;
    } execResult_t;

endpackage

// File: source/dpDecode.sv
module dpDecode (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  inValid,
    input  armIsaPkg::word_t      instruction,
    input  armIsaPkg::word_t      operandN,
    input  armIsaPkg::word_t      operandM,
    output dpPipePkg::decodedOp_t decoded
);

    armIsaPkg::dpOpcode_t   opcode;
    armIsaPkg::instrClass_t instrClass;
    logic                   isCompare;
    logic                   isDataProc;
    dpPipePkg::aluOp_t      aluOp;
    dpPipePkg::decodedOp_t  nextOp;

    assign opcode = armIsaPkg::dpOpcode_t'(instruction[armIsaPkg::OpMsb:armIsaPkg::OpLsb]);
    assign instrClass = armIsaPkg::instrClass_t'(instruction[armIsaPkg::ClassMsb -: 3]);

    assign isCompare = opcode inside {armIsaPkg::TST, armIsaPkg::TEQ,
                                      armIsaPkg::CMP, armIsaPkg::CMN};

    assign isDataProc = (instrClass == armIsaPkg::DP_IMM) ||
                        (instrClass == armIsaPkg::DP_REG_SHIFT &&
                         !instruction[armIsaPkg::ShiftByRegPos]);

    always_comb begin
        case (opcode)
            armIsaPkg::AND, armIsaPkg::TST: aluOp = dpPipePkg::AluAnd;
            armIsaPkg::EOR, armIsaPkg::TEQ: aluOp = dpPipePkg::AluXor;
            armIsaPkg::SUB, armIsaPkg::CMP: aluOp = dpPipePkg::AluSub;
            armIsaPkg::ADD, armIsaPkg::CMN: aluOp = dpPipePkg::AluAdd;
            armIsaPkg::RSB:                 aluOp = dpPipePkg::AluRsb;
            armIsaPkg::ADC:                 aluOp = dpPipePkg::AluAddC;
            armIsaPkg::SBC:                 aluOp = dpPipePkg::AluSubC;
            armIsaPkg::RSC:                 aluOp = dpPipePkg::AluRsbC;
            armIsaPkg::ORR:                 aluOp = dpPipePkg::AluOr;
            armIsaPkg::MOV:                 aluOp = dpPipePkg::AluPassB;
            armIsaPkg::BIC:                 aluOp = dpPipePkg::AluAndNotB;
            default:                        aluOp = dpPipePkg::AluNotB;  // MVN
        endcase
    end

    always_comb begin
        nextOp.valid     = 1'b1;
        nextOp.cond      = armIsaPkg::condCode_t'(
                               instruction[armIsaPkg::CondMsb:armIsaPkg::CondLsb]);
        nextOp.aluOp     = aluOp;
        nextOp.setFlags  = isCompare | instruction[armIsaPkg::SBitPos];
        nextOp.writesReg = !isCompare;
        nextOp.isImm     = (instrClass == armIsaPkg::DP_IMM);
        nextOp.shiftType = armIsaPkg::shiftType_t'(instruction[armIsaPkg::ShiftTypeMsb -: 2]);
        nextOp.shiftAmt  = instruction[armIsaPkg::ShiftAmtMsb -: 5];
        nextOp.rot       = instruction[armIsaPkg::RotMsb -: 4];
        nextOp.imm8      = instruction[armIsaPkg::Imm8Msb -: 8];
        nextOp.dest      = instruction[armIsaPkg::RdMsb -: 4];
        nextOp.operandA  = operandN;
        nextOp.operandM  = operandM;
        // Anything else rides through as a never-executed entry
        if (!isDataProc) begin
            nextOp.cond = armIsaPkg::NV;
        end
    end

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            decoded <= '0;
        end else if (inValid) begin
            decoded <= nextOp;
        end else begin
            decoded.valid <= 1'b0;  // Payload holds while idle
        end
    end

endmodule

// File: source/dpExecute.sv
module dpExecute (
    input  dpPipePkg::decodedOp_t  decoded,
    input  dpPipePkg::flags_t      statusFlags,
    output dpPipePkg::execResult_t execOut
);

    armIsaPkg::word_t  opA;
    armIsaPkg::word_t  opB;
    armIsaPkg::word_t  aluOut;
    armIsaPkg::word_t  minuend;
    armIsaPkg::word_t  subtrahend;
    logic [32:0]       sum;
    logic              carryIn;
    logic              cOut;
    logic              vOut;
    logic              arithmetic;
    logic              condPass;

    function automatic armIsaPkg::word_t rorWord(armIsaPkg::word_t value, logic [4:0] amt);
        logic [63:0] doubled;
        doubled = {value, value} >> amt;
        return doubled[31:0];
    endfunction

    assign opA = decoded.operandA;

    // Second operand
    always_comb begin
        if (decoded.isImm) begin
            opB = rorWord({24'b0, decoded.imm8}, {decoded.rot, 1'b0});
        end else begin
            case (decoded.shiftType)
                armIsaPkg::LSL: opB = decoded.operandM << decoded.shiftAmt;
                armIsaPkg::LSR: opB = decoded.operandM >> decoded.shiftAmt;
                armIsaPkg::ASR: opB = $signed(decoded.operandM) >>> decoded.shiftAmt;
                default:        opB = rorWord(decoded.operandM, decoded.shiftAmt);
            endcase
        end
    end

    assign carryIn = (decoded.aluOp inside {dpPipePkg::AluAddC, dpPipePkg::AluSubC,
                                            dpPipePkg::AluRsbC}) ? statusFlags.c : 1'b0;

    always_comb begin
        sum        = '0;
        minuend    = opA;
        subtrahend = opB;
        cOut       = 1'b0;
        vOut       = 1'b0;
        arithmetic = 1'b0;
        case (decoded.aluOp)
            dpPipePkg::AluAdd, dpPipePkg::AluAddC: begin
                arithmetic = 1'b1;
                sum        = {1'b0, opA} + {1'b0, opB} + 33'(carryIn);
                aluOut     = sum[31:0];
                cOut       = sum[32];
                vOut       = ~(opA[31] ^ opB[31]) & (opA[31] ^ aluOut[31]);
            end
            dpPipePkg::AluSub, dpPipePkg::AluSubC, dpPipePkg::AluRsb, dpPipePkg::AluRsbC: begin
                arithmetic = 1'b1;
                if (decoded.aluOp inside {dpPipePkg::AluRsb, dpPipePkg::AluRsbC}) begin
                    minuend    = opB;
                    subtrahend = opA;
                end
                aluOut = minuend - subtrahend - 32'(carryIn);
                cOut   = {1'b0, minuend} < ({1'b0, subtrahend} + 33'(carryIn));  // Borrow
                vOut   = (minuend[31] ^ subtrahend[31]) & (minuend[31] ^ aluOut[31]);
            end
            dpPipePkg::AluAnd:     aluOut = opA & opB;
            dpPipePkg::AluOr:      aluOut = opA | opB;
            dpPipePkg::AluXor:     aluOut = opA ^ opB;
            dpPipePkg::AluPassB:   aluOut = opB;
            dpPipePkg::AluNotB:    aluOut = ~opB;
            dpPipePkg::AluAndNotB: aluOut = opA & ~opB;
            default:               aluOut = '0;
        endcase
    end

    always_comb begin
        case (decoded.cond)
            armIsaPkg::EQ: condPass = statusFlags.z;
            armIsaPkg::NE: condPass = !statusFlags.z;
            armIsaPkg::CS: condPass = statusFlags.c;
            armIsaPkg::CC: condPass = !statusFlags.c;
            armIsaPkg::MI: condPass = statusFlags.n;
            armIsaPkg::PL: condPass = !statusFlags.n;
            armIsaPkg::VS: condPass = statusFlags.v;
            armIsaPkg::VC: condPass = !statusFlags.v;
            armIsaPkg::HI: condPass = statusFlags.c && !statusFlags.z;
            armIsaPkg::LS: condPass = !statusFlags.c || statusFlags.z;
            armIsaPkg::GE: condPass = (statusFlags.n == statusFlags.v);
            armIsaPkg::LT: condPass = (statusFlags.n != statusFlags.v);
            armIsaPkg::GT: condPass = !statusFlags.z && (statusFlags.n == statusFlags.v);
            armIsaPkg::LE: condPass = statusFlags.z || (statusFlags.n != statusFlags.v);
            armIsaPkg::AL: condPass = 1'b1;
            default:       condPass = 1'b0;  // NV
        endcase
    end

    always_comb begin
        execOut.valid       = decoded.valid;
        execOut.executed    = decoded.valid && condPass;
        execOut.writeEnable = decoded.valid && condPass && decoded.writesReg;
        execOut.dest        = decoded.dest;
        execOut.value       = aluOut;
        execOut.setFlags    = decoded.setFlags;
        execOut.arithmetic  = arithmetic;
        execOut.newFlags    = '{n: aluOut[31], z: (aluOut == '0), c: cOut, v: vOut};
    end

endmodule

// File: source/dpResult.sv
module dpResult (
    input  logic                   Clk,
    input  logic                   reset,
    input  dpPipePkg::execResult_t execOut,
    output dpPipePkg::flags_t      statusFlags,
    output logic                   outValid,
    output armIsaPkg::word_t       result,
    output armIsaPkg::regNum_t     resultDest,
    output logic                   writeEnable
);

    logic updateFlags;

    assign updateFlags = execOut.valid && execOut.executed && execOut.setFlags;

    // Status register
    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            statusFlags <= '0;
        end else if (updateFlags) begin
            statusFlags.n <= execOut.newFlags.n;
            statusFlags.z <= execOut.newFlags.z;
            // Logical ops keep C and V
            if (execOut.arithmetic) begin
                statusFlags.c <= execOut.newFlags.c;
                statusFlags.v <= execOut.newFlags.v;
            end
        end
    end

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            outValid    <= 1'b0;
            writeEnable <= 1'b0;
            result      <= '0;
            resultDest  <= '0;
        end else begin
            outValid    <= execOut.valid;
            writeEnable <= execOut.writeEnable;
            result      <= execOut.value;
            resultDest  <= execOut.dest;
        end
    end

endmodule

// File: source/dataProcUnit.sv
module dataProcUnit (
    input  logic               Clk,
    input  logic               reset,
    input  logic               inValid,
    input  armIsaPkg::word_t   instruction,
    input  armIsaPkg::word_t   operandN,
    input  armIsaPkg::word_t   operandM,
    output logic               outValid,
    output armIsaPkg::word_t   result,
    output armIsaPkg::regNum_t resultDest,
    output logic               writeEnable,
    output dpPipePkg::flags_t  flags
);

    dpPipePkg::decodedOp_t  decoded;
    dpPipePkg::execResult_t execOut;
    dpPipePkg::flags_t      statusFlags;

    dpDecode decodeStage (
        .Clk(Clk), .reset(reset), .inValid(inValid), .instruction(instruction),
        .operandN(operandN), .operandM(operandM), .decoded(decoded)
    );

    dpExecute executeStage (.decoded(decoded), .statusFlags(statusFlags), .execOut(execOut));

    dpResult resultStage (
        .Clk(Clk), .reset(reset), .execOut(execOut), .statusFlags(statusFlags),
        .outValid(outValid), .result(result), .resultDest(resultDest),
        .writeEnable(writeEnable)
    );

    assign flags = statusFlags;

endmodule

// File: verif/clockGen.sv
module clockGen (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(negedge Clk);
        reset = 1'b0;  // Released away from the rising edge
    end

endmodule

// File: verif/dataProcUnitTb.sv
module dataProcUnitTb;

    localparam int Fields     = 8;
    localparam int MaxRecords = 64;
    localparam int ResetLimit = 10;
    localparam int DrainLimit = 10;
    localparam int Latency    = 2;

    typedef struct packed {
        logic [31:0]        caseNum;
        logic [31:0]        due;  // Falling edge where the output must show
        armIsaPkg::word_t   result;
        armIsaPkg::regNum_t dest;
        logic               writeEnable;
        dpPipePkg::flags_t  flags;
    } expected_t;

    logic               Clk;
    logic               reset;
    logic               inValid;
    armIsaPkg::word_t   instruction;
    armIsaPkg::word_t   operandN;
    armIsaPkg::word_t   operandM;
    logic               outValid;
    armIsaPkg::word_t   result;
    armIsaPkg::regNum_t resultDest;
    logic               writeEnable;
    dpPipePkg::flags_t  flags;

    logic [31:0] cases [MaxRecords * Fields];
    expected_t   expQ [$];
    logic [31:0] cycle = '0;
    int          errorCount = 0;
    int          caseErrors = 0;
    int          checkedCount = 0;
    int          failedCount = 0;

    clockGen clocks (.Clk(Clk), .reset(reset));

    dataProcUnit DUT (.*);

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %s got %h expected %h", name, got, expected);
            caseErrors++;
        end
    endtask

    task automatic finishCase(input logic [31:0] caseNum);
        checkedCount++;
        if (caseErrors == 0) begin
            $display("Case %0d ok", caseNum);
        end else begin
            $display("Case %0d mismatch", caseNum);
            failedCount++;
            errorCount += caseErrors;
        end
        caseErrors = 0;
    endtask

    // Runs on every falling edge before new inputs go out
    task automatic checkOutputs();
        expected_t entry;
        if (outValid === 1'b1 && expQ.size() == 0) begin
            $display("Output valid with no instruction outstanding at cycle %0d", cycle);
            errorCount++;
        end else if (outValid === 1'b1 || (expQ.size() != 0 && expQ[0].due <= cycle)) begin
            entry = expQ.pop_front();
            if (outValid !== 1'b1) begin
                $display("Case %0d never produced an output", entry.caseNum);
                caseErrors++;
            end else begin
                if (entry.due != cycle) begin
                    $display("Case %0d output came at cycle %0d instead of %0d",
                             entry.caseNum, cycle, entry.due);
                    caseErrors++;
                end
                checkValue("result", result, entry.result);
                checkValue("resultDest", {28'b0, resultDest}, {28'b0, entry.dest});
                checkValue("writeEnable", {31'b0, writeEnable}, {31'b0, entry.writeEnable});
                checkValue("flags", {28'b0, flags}, {28'b0, entry.flags});
            end
            finishCase(entry.caseNum);
        end
    endtask

    initial begin
        expected_t   entry;
        int          base;
        int          waitCount;
        logic [31:0] caseCount;
        inValid     = 1'b0;
        instruction = '0;
        operandN    = '0;
        operandM    = '0;
        caseCount   = '0;
        for (int i = 0; i < MaxRecords * Fields; i++) begin
            cases[i] = 32'hE000_0000 | i;  // Unfilled entries read as end of data
        end
        $readmemh("verif/dpCases.txt", cases);

        waitCount = 0;
        while (reset !== 1'b0 && waitCount < ResetLimit) begin
            @(posedge Clk);
            waitCount++;
        end
        if (reset !== 1'b0) begin
            $display("Reset was never released");
            errorCount++;
        end
        @(negedge Clk);
        cycle = cycle + 1;
        // Everything zero straight out of reset
        checkValue("outValid", {31'b0, outValid}, 32'h0);
        checkValue("result", result, 32'h0);
        checkValue("resultDest", {28'b0, resultDest}, 32'h0);
        checkValue("writeEnable", {31'b0, writeEnable}, 32'h0);
        checkValue("flags", {28'b0, flags}, 32'h0);
        finishCase(0);

        base = 0;
        while (base < MaxRecords * Fields && cases[base] <= 32'd1) begin
            @(negedge Clk);
            cycle = cycle + 1;
            checkOutputs();
            inValid     = cases[base][0];
            instruction = cases[base + 1];
            operandN    = cases[base + 2];
            operandM    = cases[base + 3];
            if (cases[base][0]) begin
                caseCount         = caseCount + 1;
                entry.caseNum     = caseCount;
                entry.due         = cycle + Latency;
                entry.result      = cases[base + 4];
                entry.dest        = cases[base + 5][3:0];
                entry.writeEnable = cases[base + 6][0];
                entry.flags       = cases[base + 7][3:0];
                expQ.push_back(entry);
            end
            base += Fields;
        end

        waitCount = 0;
        while (expQ.size() != 0 && waitCount < DrainLimit) begin
            @(negedge Clk);
            cycle = cycle + 1;
            checkOutputs();
            inValid = 1'b0;
            waitCount++;
        end
        if (expQ.size() != 0) begin
            $display("Timed out with %0d outputs still outstanding", expQ.size());
            errorCount++;
        end

        $display("Cases checked %0d, failed %0d, errors %0d",
                 checkedCount, failedCount, errorCount);
        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: verif/dpCases.txt
// kind instruction operandN operandM result resultDest writeEnable flags
// kind 1 drives an instruction and kind 0 is an idle cycle. Flags are n z c v
// Arithmetic flags, logic and reverse operations
1 E0921000 FFFFFFFF 00000001 00000000 1 1 6
1 E0B24000 00000001 00000002 00000004 4 1 0
1 E0923000 7FFFFFFF 00000001 80000000 3 1 9
1 E0525000 00000000 80000000 80000000 5 1 B
1 E0121000 F0F0F0F0 0FF00FF0 00F000F0 1 1 3
1 E0322000 FFFF0000 0000FFFF FFFFFFFF 2 1 B
1 E1823000 12000000 00000034 12000034 3 1 B
1 E1D24000 FFFFFFFF FFFFFFFF 00000000 4 1 7
1 E1F26000 00000000 0000FFFF FFFF0000 6 1 B
1 E0727000 00000005 00000003 FFFFFFFE 7 1 A
1 E0E28000 00000001 00000010 0000000E 8 1 A
1 E0D26000 00000010 00000003 0000000C 6 1 0
// Shifter forms
1 E1A21200 00000000 8000000F 000000F0 1 1 0
1 E1A22420 00000000 80000000 00800000 2 1 0
1 E1A23440 00000000 80000000 FF800000 3 1 0
1 E1A24260 00000000 12345678 81234567 4 1 0
1 E1A25040 00000000 80000001 80000001 5 1 0
1 E3A264FF 00000000 00000000 FF000000 6 1 0
1 E2827101 00001000 00000000 40001000 7 1 0
// Compares without the S bit
1 E1420000 00000005 00000005 00000000 0 0 4
1 E1020000 80000000 80000001 80000000 0 0 8
1 E1220000 0000AAAA 0000AAAA 00000000 0 0 4
1 E1620000 FFFFFFFF 00000001 00000000 0 0 6
// Conditions EQ to NV, failing ones carry the S bit
1 03A090C0 00000000 00000000 000000C0 9 1 6
1 13B090C1 00000000 00000000 000000C1 9 0 6
1 23A090C2 00000000 00000000 000000C2 9 1 6
1 33B090C3 00000000 00000000 000000C3 9 0 6
1 43B090C4 00000000 00000000 000000C4 9 0 6
1 53A090C5 00000000 00000000 000000C5 9 1 6
1 63B090C6 00000000 00000000 000000C6 9 0 6
1 73A090C7 00000000 00000000 000000C7 9 1 6
1 83B090C8 00000000 00000000 000000C8 9 0 6
1 93A090C9 00000000 00000000 000000C9 9 1 6
1 A3A090CA 00000000 00000000 000000CA 9 1 6
1 B3B090CB 00000000 00000000 000000CB 9 0 6
1 C3B090CC 00000000 00000000 000000CC 9 0 6
1 D3A090CD 00000000 00000000 000000CD 9 1 6
1 E3A090CE 00000000 00000000 000000CE 9 1 6
1 F3B090CF 00000000 00000000 000000CF 9 0 6
// Idle cycle, then a load/store encoding that must have no effect
0 00000000 00000000 00000000 00000000 0 0 0
1 E4000000 12345678 00000000 00000000 0 0 6

// File: all.f
source/armIsaPkg.sv
source/dpPipePkg.sv
source/dpDecode.sv
source/dpExecute.sv
source/dpResult.sv
source/dataProcUnit.sv
verif/clockGen.sv
verif/dataProcUnitTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = dataProcUnitTb
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log

SOURCES  = $(shell cat $(FILELIST))
BIN      = $(BUILDDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
